// File: compile.f
source/bus_pkg.sv
source/cache_pkg.sv
source/line_fill_controller.sv
source/refill_arbiter.sv
source/line_cache.sv
source/fetch_unit.sv
source/cpu_mem_top.sv
test/tb_clock.sv
test/bus_memory_model.sv
test/cpu_mem_top_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module cpu_mem_top_tb -f compile.f \
  -o cpu_mem_top_tb \
  && ./obj_dir/cpu_mem_top_tb | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: source/bus_pkg.sv
package bus_pkg;

  localparam int bus_data_width = 64;
  localparam int bus_tag_width = 13;

  // a line read comes back as eight word beats
  localparam int beats_per_line = 8;
  localparam int beat_count_bits = $clog2(beats_per_line);

  // request kind sits in the top tag bit, requesting cache in bit 0
  localparam int bus_kind_bit = bus_tag_width - 1;
  localparam int bus_src_bit = 0;

  typedef enum logic [0:0] {
    kind_none      = 1'b0,
    kind_read_line = 1'b1
  } bus_kind_t;

endpackage

// File: source/cache_pkg.sv
package cache_pkg;

  localparam int addr_width = 64;
  localparam int word_bits = 64;
  localparam int instr_bits = 32;

  // 64-byte lines, 16 lines per cache
  localparam int line_bits = 512;
  localparam int index_bits = 4;
  localparam int offset_bits = 6;
  localparam int word_offset_bits = 3;
  localparam int word_sel_bits = offset_bits - word_offset_bits;
  localparam int tag_bits = addr_width - index_bits - offset_bits;
  localparam int cache_lines = 1 << index_bits;

  typedef logic [line_bits-1:0] line_t;

  typedef enum logic {
    src_icache,
    src_dcache
  } src_t;

  typedef struct packed {
    logic [addr_width-1:0] addr;
  } cache_req_t;

  typedef struct packed {
    logic [word_bits-1:0]  data;
    logic [addr_width-1:0] addr;
  } cache_resp_t;

  typedef struct packed {
    logic [addr_width-1:0] line_addr;
    src_t                  source;
  } fill_req_t;

  typedef struct packed {
    logic [addr_width-1:0] pc;
    logic [instr_bits-1:0] instr;
  } fetch_out_t;

endpackage

// File: source/cpu_mem_top.sv
module cpu_mem_top (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [cache_pkg::addr_width-1:0]    entry,
  input  logic                                redirect_valid,
  input  logic [cache_pkg::addr_width-1:0]    redirect_pc,
  output logic                                instr_valid,
  input  logic                                instr_ready,
  output cache_pkg::fetch_out_t               instr,
  input  logic                                load_req_valid,
  output logic                                load_req_ready,
  input  cache_pkg::cache_req_t               load_req,
  output logic                                load_resp_valid,
  input  logic                                load_resp_ready,
  output cache_pkg::cache_resp_t              load_resp,
  output logic                                bus_reqcyc,
  output logic                                bus_respack,
  output logic [bus_pkg::bus_data_width-1:0]  bus_req,
  output logic [bus_pkg::bus_tag_width-1:0]   bus_reqtag,
  input  logic                                bus_respcyc,
  input  logic                                bus_reqack,
  input  logic [bus_pkg::bus_data_width-1:0]  bus_resp,
  input  logic [bus_pkg::bus_tag_width-1:0]   bus_resptag
);
  import cache_pkg::*;

  logic ic_req_valid;
  logic ic_req_ready;
  cache_req_t ic_req;
  logic ic_resp_valid;
  cache_resp_t ic_resp;
  logic i_fill_valid;
  logic i_fill_ready;
  fill_req_t i_fill;
  logic d_fill_valid;
  logic d_fill_ready;
  fill_req_t d_fill;
  logic i_done;
  logic d_done;
  line_t arb_line;
  logic mem_fill_valid;
  logic mem_fill_ready;
  fill_req_t mem_fill;
  logic mem_done;
  line_t mem_line;

  fetch_unit fetch (
    .clk(clk), .reset(reset), .entry(entry),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .req_valid(ic_req_valid), .req_ready(ic_req_ready), .req(ic_req),
    .resp_valid(ic_resp_valid), .resp(ic_resp),
    .instr_valid(instr_valid), .instr_ready(instr_ready), .instr(instr)
  );

  // fetch always has room, so the instruction answer is never held back
  line_cache #(.fill_source(src_icache)) instr_cache (
    .clk(clk), .reset(reset),
    .req_valid(ic_req_valid), .req_ready(ic_req_ready), .req(ic_req),
    .resp_valid(ic_resp_valid), .resp_ready(1'b1), .resp(ic_resp),
    .fill_valid(i_fill_valid), .fill_ready(i_fill_ready), .fill(i_fill),
    .fill_done(i_done), .fill_line(arb_line)
  );

  line_cache #(.fill_source(src_dcache)) data_cache (
    .clk(clk), .reset(reset),
    .req_valid(load_req_valid), .req_ready(load_req_ready), .req(load_req),
    .resp_valid(load_resp_valid), .resp_ready(load_resp_ready), .resp(load_resp),
    .fill_valid(d_fill_valid), .fill_ready(d_fill_ready), .fill(d_fill),
    .fill_done(d_done), .fill_line(arb_line)
  );

  refill_arbiter arbiter (
    .clk(clk), .reset(reset),
    .i_fill_valid(i_fill_valid), .i_fill_ready(i_fill_ready), .i_fill(i_fill),
    .d_fill_valid(d_fill_valid), .d_fill_ready(d_fill_ready), .d_fill(d_fill),
    .i_done(i_done), .d_done(d_done), .line(arb_line),
    .mem_fill_valid(mem_fill_valid), .mem_fill_ready(mem_fill_ready), .mem_fill(mem_fill),
    .mem_done(mem_done), .mem_line(mem_line)
  );

  line_fill_controller mem_ctrl (
    .clk(clk), .reset(reset),
    .fill_valid(mem_fill_valid), .fill_ready(mem_fill_ready), .fill_req(mem_fill),
    .done(mem_done), .line(mem_line),
    .bus_reqcyc(bus_reqcyc), .bus_respack(bus_respack),
    .bus_req(bus_req), .bus_reqtag(bus_reqtag),
    .bus_reqack(bus_reqack), .bus_respcyc(bus_respcyc),
    .bus_resp(bus_resp), .bus_resptag(bus_resptag)
  );

endmodule

// File: source/fetch_unit.sv
module fetch_unit (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [cache_pkg::addr_width-1:0] entry,
  input  logic                             redirect_valid,
  input  logic [cache_pkg::addr_width-1:0] redirect_pc,
  output logic                             req_valid,
  input  logic                             req_ready,
  output cache_pkg::cache_req_t            req,
  input  logic                             resp_valid,
  input  cache_pkg::cache_resp_t           resp,
  output logic                             instr_valid,
  input  logic                             instr_ready,
  output cache_pkg::fetch_out_t            instr
);
  import cache_pkg::*;

  logic [addr_width-1:0] pc_q;
  logic epoch_q;
  logic req_valid_q;
  logic [addr_width-1:0] req_addr_q;
  logic req_epoch_q;
  logic inflight_q;
  logic infl_epoch_q;
  logic out_valid_q;
  fetch_out_t out_q;
  logic issue;
  logic keep;
  logic [instr_bits-1:0] half;

  // issue only when the output slot will still be free when the answer lands
  assign issue = !redirect_valid && !req_valid_q && !inflight_q &&
                 (!out_valid_q || instr_ready);

  // answers from before a redirect carry the old epoch
  assign keep = resp_valid && inflight_q && (infl_epoch_q == epoch_q) && !redirect_valid;
  assign half = resp.addr[word_offset_bits-1] ? resp.data[word_bits-1 -: instr_bits] :
                                                resp.data[instr_bits-1:0];

  assign req_valid = req_valid_q;
  assign req.addr = req_addr_q;
  assign instr_valid = out_valid_q;
  assign instr = out_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= entry;
      epoch_q <= 1'b0;
      req_valid_q <= 1'b0;
      inflight_q <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (redirect_valid) begin
        pc_q <= redirect_pc;
        epoch_q <= ~epoch_q;
      end else if (issue) begin
        pc_q <= pc_q + addr_width'(instr_bits / 8);
      end
      if (issue) begin
        req_valid_q <= 1'b1;
      end else if (req_valid_q && req_ready) begin
        req_valid_q <= 1'b0;
      end
      if (req_valid_q && req_ready) begin
        inflight_q <= 1'b1;
      end else if (resp_valid) begin
        inflight_q <= 1'b0;
      end
      if (redirect_valid) begin
        out_valid_q <= 1'b0;
      end else if (keep) begin
        out_valid_q <= 1'b1;
      end else if (instr_ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr_q <= pc_q;
      req_epoch_q <= epoch_q;
    end
    if (req_valid_q && req_ready) begin
      infl_epoch_q <= req_epoch_q;
    end
    if (keep) begin
      out_q.pc <= resp.addr;
      out_q.instr <= half;
    end
  end

endmodule

// File: source/line_cache.sv
module line_cache #(
  parameter cache_pkg::src_t fill_source = cache_pkg::src_icache
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  cache_pkg::cache_req_t  req,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output cache_pkg::cache_resp_t resp,
  output logic                   fill_valid,
  input  logic                   fill_ready,
  output cache_pkg::fill_req_t   fill,
  input  logic                   fill_done,
  input  cache_pkg::line_t       fill_line
);
  import cache_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_wait
  } cache_state_t;

  cache_state_t state;
  logic [cache_lines-1:0] valid_q;
  logic [tag_bits-1:0] tag_q [cache_lines];
  line_t data_q [cache_lines];
  cache_req_t pend_q;
  logic resp_valid_q;
  cache_resp_t resp_q;

  logic [index_bits-1:0] req_index;
  logic [tag_bits-1:0] req_tag;
  logic [word_sel_bits-1:0] req_word;
  logic [index_bits-1:0] pend_index;
  logic [tag_bits-1:0] pend_tag;
  logic [word_sel_bits-1:0] pend_word;
  logic accept;
  logic hit;
  logic install;

  assign req_index = req.addr[offset_bits +: index_bits];
  assign req_tag = req.addr[addr_width-1 -: tag_bits];
  assign req_word = req.addr[word_offset_bits +: word_sel_bits];
  assign pend_index = pend_q.addr[offset_bits +: index_bits];
  assign pend_tag = pend_q.addr[addr_width-1 -: tag_bits];
  assign pend_word = pend_q.addr[word_offset_bits +: word_sel_bits];

  assign hit = valid_q[req_index] && (tag_q[req_index] == req_tag);

  // no new request while a miss runs or an answer is still waiting
  assign req_ready = (state == st_idle) && (!resp_valid_q || resp_ready);
  assign accept = req_valid && req_ready;
  assign install = (state == st_wait) && fill_done;

  assign fill_valid = (state == st_fill);
  assign fill = '{
    line_addr: {pend_q.addr[addr_width-1:offset_bits], {offset_bits{1'b0}}},
    source:    fill_source
  };

  assign resp_valid = resp_valid_q;
  assign resp = resp_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      valid_q <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      if (resp_valid_q && resp_ready) begin
        resp_valid_q <= 1'b0;
      end
      case (state)
        st_idle: begin
          if (accept && hit) begin
            resp_valid_q <= 1'b1;
          end else if (accept) begin
            state <= st_fill;
          end
        end
        st_fill: begin
          if (fill_ready) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (fill_done) begin
            valid_q[pend_index] <= 1'b1;
            resp_valid_q <= 1'b1;
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pend_q <= req;
      resp_q.addr <= req.addr;
      resp_q.data <= data_q[req_index][req_word*word_bits +: word_bits];
    end
    // the pending request is answered straight from the incoming line
    if (install) begin
      tag_q[pend_index] <= pend_tag;
      data_q[pend_index] <= fill_line;
      resp_q.data <= fill_line[pend_word*word_bits +: word_bits];
    end
  end

  a_no_resp_during_fill: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_valid) |-> (state == st_idle) && ($past(accept && hit) || $past(install)));

endmodule

// File: source/line_fill_controller.sv
module line_fill_controller (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                fill_valid,
  output logic                                fill_ready,
  input  cache_pkg::fill_req_t                fill_req,
  output logic                                done,
  output cache_pkg::line_t                    line,
  output logic                                bus_reqcyc,
  output logic                                bus_respack,
  output logic [bus_pkg::bus_data_width-1:0]  bus_req,
  output logic [bus_pkg::bus_tag_width-1:0]   bus_reqtag,
  input  logic                                bus_reqack,
  input  logic                                bus_respcyc,
  input  logic [bus_pkg::bus_data_width-1:0]  bus_resp,
  input  logic [bus_pkg::bus_tag_width-1:0]   bus_resptag
);
  import bus_pkg::*;
  import cache_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_collect,
    st_done
  } fill_state_t;

  fill_state_t state;
  logic [addr_width-1:0] addr_q;
  logic [bus_tag_width-1:0] tag_q;
  logic [bus_tag_width-1:0] tag_d;
  logic [beat_count_bits-1:0] beat_q;
  line_t line_q;
  logic beat;

  always_comb begin
    tag_d = '0;
    tag_d[bus_kind_bit] = kind_read_line;
    tag_d[bus_src_bit] = (fill_req.source == src_dcache);
  end

  assign fill_ready = (state == st_idle);
  assign bus_reqcyc = (state == st_request);
  assign bus_req = addr_q;
  assign bus_reqtag = tag_q;

  // only beats carrying our own tag are taken
  assign beat = (state == st_collect) && bus_respcyc && (bus_resptag == tag_q);
  assign bus_respack = beat;

  assign done = (state == st_done);
  assign line = line_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      beat_q <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (fill_valid) begin
            state <= st_request;
          end
        end
        st_request: begin
          if (bus_reqack) begin
            state <= st_collect;
            beat_q <= '0;
          end
        end
        st_collect: begin
          if (beat) begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == beat_count_bits'(beats_per_line - 1)) begin
              state <= st_done;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fill_valid && fill_ready) begin
      addr_q <= {fill_req.line_addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
      tag_q <= tag_d;
    end
    // first beat is the lowest word, it ends up at the bottom after eight shifts
    if (beat) begin
      line_q <= {bus_resp, line_q[line_bits-1:bus_data_width]};
    end
  end

  a_respack_needs_respcyc: assert property (@(posedge clk) disable iff (reset)
    bus_respack |-> bus_respcyc);

endmodule

// File: source/refill_arbiter.sv
module refill_arbiter (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_fill_valid,
  output logic                 i_fill_ready,
  input  cache_pkg::fill_req_t i_fill,
  input  logic                 d_fill_valid,
  output logic                 d_fill_ready,
  input  cache_pkg::fill_req_t d_fill,
  output logic                 i_done,
  output logic                 d_done,
  output cache_pkg::line_t     line,
  output logic                 mem_fill_valid,
  input  logic                 mem_fill_ready,
  output cache_pkg::fill_req_t mem_fill,
  input  logic                 mem_done,
  input  cache_pkg::line_t     mem_line
);
  import cache_pkg::*;

  logic busy_q;
  src_t owner_q;
  src_t pick;

  // instruction side wins a tie
  assign pick = i_fill_valid ? src_icache : src_dcache;

  assign mem_fill_valid = !busy_q && (i_fill_valid || d_fill_valid);
  assign mem_fill = (pick == src_icache) ? i_fill : d_fill;
  assign i_fill_ready = !busy_q && mem_fill_ready && (pick == src_icache);
  assign d_fill_ready = !busy_q && mem_fill_ready && (pick == src_dcache);

  // done and the line go back to whoever holds the grant
  assign i_done = mem_done && busy_q && (owner_q == src_icache);
  assign d_done = mem_done && busy_q && (owner_q == src_dcache);
  assign line = mem_line;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      owner_q <= src_icache;
    end else begin
      if (mem_fill_valid && mem_fill_ready) begin
        busy_q <= 1'b1;
        owner_q <= pick;
      end else if (mem_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // a finished line always belongs to a granted fill
  a_done_only_when_granted: assert property (@(posedge clk) disable iff (reset)
    mem_done |-> busy_q);

endmodule

// File: test/bus_memory_model.sv
module bus_memory_model (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               reqcyc,
  input  logic [bus_pkg::bus_data_width-1:0] req,
  input  logic [bus_pkg::bus_tag_width-1:0]  reqtag,
  output logic                               reqack,
  output logic                               respcyc,
  output logic [bus_pkg::bus_data_width-1:0] resp,
  output logic [bus_pkg::bus_tag_width-1:0]  resptag,
  input  logic                               respack,
  output int                                 icache_reads,
  output int                                 dcache_reads
);
  import bus_pkg::*;

  logic [bus_data_width-1:0] line_addr;
  logic [bus_tag_width-1:0] tag;

  // low half is the aligned word address, high half its inverse
  function automatic logic [63:0] memory_word(input logic [63:0] addr);
    logic [63:0] w;
    w = {addr[63:3], 3'b000};
    return {~w[31:0], w[31:0]};
  endfunction

  initial begin
    reqack = 1'b0;
    respcyc = 1'b0;
    resp = '0;
    resptag = '0;
    icache_reads = 0;
    dcache_reads = 0;
    forever begin
      @(posedge clk);
      if (!reset && reqcyc) begin
        line_addr = req;
        tag = reqtag;
        if (bus_kind_t'(tag[bus_kind_bit]) == kind_read_line) begin
          if (tag[bus_src_bit]) begin
            dcache_reads++;
          end else begin
            icache_reads++;
          end
        end
        repeat ($urandom_range(2, 0)) @(posedge clk);
        #2;
        reqack = 1'b1;
        @(posedge clk);
        #2;
        reqack = 1'b0;
        // memory latency before the first beat
        repeat ($urandom_range(6, 0)) begin
          @(posedge clk);
          #2;
        end
        for (int k = 0; k < beats_per_line; k++) begin
          // now and then an idle cycle between beats
          if ($urandom_range(3, 0) == 0) begin
            respcyc = 1'b0;
            @(posedge clk);
            #2;
          end
          respcyc = 1'b1;
          resp = memory_word(line_addr + 64'(8 * k));
          resptag = tag;
          @(posedge clk);
          while (!respack) begin
            @(posedge clk);
          end
          #2;
        end
        respcyc = 1'b0;
      end
    end
  end

endmodule

// File: test/cpu_mem_top_tb.sv
module cpu_mem_top_tb;
  import bus_pkg::*;
  import cache_pkg::*;

  localparam logic [63:0] entry_pc = 64'h0000_0000_8000_0000;
  localparam logic [63:0] load_base = 64'h0000_0000_4000_0000;
  localparam logic [63:0] hit_base = 64'h0000_0000_8000_2000;
  localparam int seq_fetches = 64;
  localparam int redirects = 4;
  localparam int fetches_per_redirect = 10;
  localparam int planned_fetches = seq_fetches + redirects * fetches_per_redirect + 16 + 13;
  localparam int planned_loads = 32;
  localparam int miss_cycles = 200;
  localparam longint timeout = longint'(planned_fetches + planned_loads) * miss_cycles * 20;

  logic clk;
  logic reset;
  logic [addr_width-1:0] entry;
  logic redirect_valid;
  logic [addr_width-1:0] redirect_pc;
  logic instr_valid;
  logic instr_ready;
  fetch_out_t instr;
  logic load_req_valid;
  logic load_req_ready;
  cache_req_t load_req;
  logic load_resp_valid;
  logic load_resp_ready;
  cache_resp_t load_resp;
  logic bus_reqcyc;
  logic bus_respack;
  logic [bus_data_width-1:0] bus_req;
  logic [bus_tag_width-1:0] bus_reqtag;
  logic bus_respcyc;
  logic bus_reqack;
  logic [bus_data_width-1:0] bus_resp;
  logic [bus_tag_width-1:0] bus_resptag;
  int icache_reads;
  int dcache_reads;

  logic [63:0] exp_pc;
  logic after_redirect;
  logic held_valid;
  fetch_out_t held_instr;
  logic [63:0] load_addrs [$];
  logic load_pending;
  logic [63:0] load_front;
  logic quiet;
  logic traffic_done;

  tb_clock clock_gen (.clk(clk), .reset(reset));

  bus_memory_model memory (
    .clk(clk), .reset(reset),
    .reqcyc(bus_reqcyc), .req(bus_req), .reqtag(bus_reqtag), .reqack(bus_reqack),
    .respcyc(bus_respcyc), .resp(bus_resp), .resptag(bus_resptag), .respack(bus_respack),
    .icache_reads(icache_reads), .dcache_reads(dcache_reads)
  );

  cpu_mem_top i_cpu_mem_top (.*);

  function automatic logic [31:0] expected_instr(input logic [63:0] a);
    logic [63:0] below;
    below = a - 64'd4;
    return a[2] ? ~below[31:0] : a[31:0];
  endfunction

  function automatic logic [63:0] expected_word(input logic [63:0] a);
    logic [63:0] w;
    w = {a[63:3], 3'b000};
    return {~w[31:0], w[31:0]};
  endfunction

  task automatic report_mismatch(input string test, input logic [127:0] expected,
                                 input logic [127:0] actual);
    $display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic take_instrs(input int count);
    int taken;
    taken = 0;
    instr_ready = ($urandom_range(3, 0) != 0);
    while (taken < count) begin
      @(posedge clk);
      if (instr_valid && instr_ready) begin
        taken++;
      end
      #2;
      instr_ready = ($urandom_range(3, 0) != 0);
    end
  endtask

  task automatic redirect_to(input logic [63:0] pc);
    @(posedge clk);
    #2;
    redirect_valid = 1'b1;
    redirect_pc = pc;
    @(posedge clk);
    #2;
    redirect_valid = 1'b0;
  endtask

  task automatic run_loads(input int count);
    int sent;
    logic accepted;
    for (sent = 0; sent < count; sent++) begin
      load_req_valid = 1'b1;
      load_req.addr = load_base + 64'($urandom_range(2047, 0));
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        accepted = load_req_ready;
        #2;
        load_resp_ready = ($urandom_range(1, 0) != 0);
      end
    end
    load_req_valid = 1'b0;
    while (load_pending || load_resp_valid) begin
      @(posedge clk);
      #2;
      load_resp_ready = 1'b1;
    end
  endtask

  // expected pc of the instruction at the output, and the held output under backpressure
  always @(posedge clk) begin
    if (reset) begin
      exp_pc <= entry;
      after_redirect <= 1'b0;
    end else if (redirect_valid) begin
      exp_pc <= redirect_pc;
      after_redirect <= 1'b1;
    end else if (instr_valid && instr_ready) begin
      exp_pc <= exp_pc + 64'd4;
      after_redirect <= 1'b0;
    end
    held_valid <= !reset && instr_valid && !instr_ready && !redirect_valid;
    held_instr <= instr;
  end

  // load addresses in request order
  always @(posedge clk) begin
    if (reset) begin
      load_addrs.delete();
    end else begin
      if (load_resp_valid && load_resp_ready && load_addrs.size() != 0) begin
        void'(load_addrs.pop_front());
      end
      if (load_req_valid && load_req_ready) begin
        load_addrs.push_back(load_req.addr);
      end
    end
    load_pending <= (load_addrs.size() != 0);
    load_front <= (load_addrs.size() != 0) ? load_addrs[0] : '0;
  end

  a_seq_fetch_pc: assert property (@(posedge clk) disable iff (reset)
      instr_valid && !after_redirect |-> instr.pc == exp_pc)
    else report_mismatch("seq_fetch pc", $sampled(exp_pc), $sampled(instr.pc));

  a_seq_fetch_instr: assert property (@(posedge clk) disable iff (reset)
      instr_valid |-> instr.instr == expected_instr(instr.pc))
    else report_mismatch("seq_fetch instr", expected_instr($sampled(instr.pc)),
                         $sampled(instr.instr));

  a_redirect_pc: assert property (@(posedge clk) disable iff (reset)
      instr_valid && after_redirect |-> instr.pc == exp_pc)
    else report_mismatch("redirect pc", $sampled(exp_pc), $sampled(instr.pc));

  a_backpressure: assert property (@(posedge clk) disable iff (reset)
      held_valid |-> instr_valid && instr == held_instr)
    else report_mismatch("backpressure", {1'b1, $sampled(held_instr)},
                         {$sampled(instr_valid), $sampled(instr)});

  a_load_order: assert property (@(posedge clk) disable iff (reset)
      load_resp_valid |-> load_pending && load_resp.addr == load_front)
    else report_mismatch("load_data order", $sampled(load_front), $sampled(load_resp.addr));

  a_load_word: assert property (@(posedge clk) disable iff (reset)
      load_resp_valid |-> load_resp.data == expected_word(load_resp.addr))
    else report_mismatch("load_data word", expected_word($sampled(load_resp.addr)),
                         $sampled(load_resp.data));

  a_bus_kind: assert property (@(posedge clk) disable iff (reset)
      bus_reqcyc |-> bus_reqtag[bus_kind_bit] == kind_read_line)
    else report_mismatch("shared_refill kind", kind_read_line,
                         $sampled(bus_reqtag[bus_kind_bit]));

  // a line read always names the first byte of a line
  a_bus_line_addr: assert property (@(posedge clk) disable iff (reset)
      bus_reqcyc |-> bus_req[offset_bits-1:0] == '0)
    else report_mismatch("shared_refill line address", 6'd0,
                         $sampled(bus_req[offset_bits-1:0]));

  a_bus_respack: assert property (@(posedge clk) disable iff (reset)
      bus_respack |-> bus_respcyc)
    else report_mismatch("shared_refill respack", 1'b1, $sampled(bus_respcyc));

  a_shared_refill: assert property (@(posedge clk) disable iff (reset)
      traffic_done |-> icache_reads != 0 && dcache_reads != 0)
    else report_mismatch("shared_refill", 2'b11,
                         {$sampled(icache_reads != 0), $sampled(dcache_reads != 0)});

  a_hit_no_bus: assert property (@(posedge clk) disable iff (reset)
      quiet |-> !bus_reqcyc)
    else report_mismatch("hit_no_bus", 1'b0, $sampled(bus_reqcyc));

  initial begin
    #(timeout);
    $display("watchdog: simulation still running after %0d time units", timeout);
    $display("FAIL: see errors above");
    $fatal(1);
  end

  initial begin
    void'($urandom(68288));
    entry = entry_pc;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    instr_ready = 1'b0;
    load_req_valid = 1'b0;
    load_req = '0;
    load_resp_ready = 1'b0;
    quiet = 1'b0;
    traffic_done = 1'b0;
    @(negedge reset);
    @(posedge clk);
    #2;
    // fetch misses and load misses compete for the one controller
    fork
      begin
        take_instrs(seq_fetches);
        repeat (redirects) begin
          redirect_to(entry_pc + 64'($urandom_range(255, 0)) * 64'd4);
          take_instrs(fetches_per_redirect);
        end
      end
      run_loads(planned_loads);
    join
    // fill one line, come back to it and stay inside it
    instr_ready = 1'b0;
    redirect_to(hit_base);
    take_instrs(16);
    instr_ready = 1'b0;
    redirect_to(hit_base);
    take_instrs(1);
    quiet = 1'b1;
    take_instrs(12);
    quiet = 1'b0;
    traffic_done = 1'b1;
    repeat (2) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: test/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic reset
);
  localparam int period = 20;
  localparam int reset_cycles = 4;

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset falls a little after the edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule
